//--- src/gemm_pkg.sv
// Shared definitions of the GEMM control front end: array geometry, the
// AXI4-Lite register map and the structs passed between the blocks.
// RTL files refer to these items by scoped names.
package gemm_pkg;

  // Compute array geometry
  localparam int unsigned ARRAY_WIDTH  = 4;
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned PIPE_REGS    = 1;
  localparam int unsigned TILE_COLS    = ARRAY_HEIGHT * (PIPE_REGS + 1);
  localparam int unsigned ELEM_BYTES   = 2;
  localparam int unsigned TILE_BYTES   = TILE_COLS * ELEM_BYTES;

  // Shift amounts for the rounded-up divisions
  localparam int unsigned ARRAY_SHIFT = $clog2(ARRAY_WIDTH);
  localparam int unsigned TILE_SHIFT  = $clog2(TILE_COLS);

  // Streams and their ids
  localparam int unsigned N_STREAMS = 3;
  localparam int unsigned SID_BITS  = $clog2(N_STREAMS);
  localparam int unsigned STREAM_X  = 0;
  localparam int unsigned STREAM_W  = 1;
  localparam int unsigned STREAM_Y  = 2;

  // One multiplier bit per cycle
  localparam int unsigned MULT_STEPS = 16;

  // Register map, byte offsets
  localparam int unsigned REG_AW = 8;
  localparam logic [REG_AW-1:0] REG_X_ADDR  = 8'h00;
  localparam logic [REG_AW-1:0] REG_W_ADDR  = 8'h04;
  localparam logic [REG_AW-1:0] REG_Y_ADDR  = 8'h08;
  localparam logic [REG_AW-1:0] REG_MK      = 8'h0C;
  localparam logic [REG_AW-1:0] REG_N       = 8'h10;
  localparam logic [REG_AW-1:0] REG_CTRL    = 8'h14;
  localparam logic [REG_AW-1:0] REG_STATUS  = 8'h18;
  localparam logic [REG_AW-1:0] REG_TILES   = 8'h1C;
  localparam logic [REG_AW-1:0] REG_X_READS = 8'h20;

  typedef struct packed {
    logic [31:0] x_addr;
    logic [31:0] w_addr;
    logic [31:0] y_addr;
    logic [15:0] m_size;
    logic [15:0] k_size;
    logic [15:0] n_size;
  } job_cfg_t;

  typedef struct packed {
    logic [31:0] base;
    logic [31:0] stride;
    logic [31:0] len;
  } stream_desc_t;

  typedef struct packed {
    logic [31:0] tot_tiles;
    logic [47:0] tot_x_read;
  } tile_info_t;

  typedef struct packed {
    logic [31:0]         addr;
    logic [SID_BITS-1:0] sid;
  } addr_req_t;

endpackage

//--- src/gemm_seq_mult.sv
// Sequential shift-add multiplier, one bit of a_i per cycle.
// The first bit is taken on the start cycle, so valid_o rises 16 cycles
// after start_i and stays high with the product until the next start.
module gemm_seq_mult (
  input  logic        clk_int,
  input  logic        rst_ni,
  input  logic        start_i,
  input  logic [15:0] a_i,
  input  logic [31:0] b_i,
  output logic        valid_o,
  output logic [47:0] prod_o
);

  logic [15:0]                            a_q;
  logic [47:0]                            b_q;
  logic [$clog2(gemm_pkg::MULT_STEPS)-1:0] cnt_q;
  logic                                   busy_q;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      valid_o <= 1'b0;
      cnt_q   <= '0;
    end else if (start_i) begin
      busy_q  <= 1'b1;
      valid_o <= 1'b0;
      cnt_q   <= 1;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == gemm_pkg::MULT_STEPS - 1) begin
        busy_q  <= 1'b0;
        valid_o <= 1'b1;
      end
    end
  end

  // Partial product accumulation
  always_ff @(posedge clk_int) begin
    if (start_i) begin
      prod_o <= a_i[0] ? {16'h0000, b_i} : '0;
      a_q    <= a_i >> 1;
      b_q    <= {15'd0, b_i, 1'b0};
    end else if (busy_q) begin
      if (a_q[0]) begin
        prod_o <= prod_o + b_q;
      end
      a_q <= a_q >> 1;
      b_q <= b_q << 1;
    end
  end

endmodule

//--- src/gemm_regfile.sv
// AXI4-Lite slave holding the job registers of the GEMM front end.
// A write of 1 to CTRL bit 0 starts a job when not busy; STATUS shows
// busy and done, TILES and X_READS read back the tiler counts.
module gemm_regfile (
  input  logic                            clk_int,
  input  logic                            rst_ni,
  input  logic [gemm_pkg::REG_AW-1:0]     awaddr_i,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  logic [31:0]                     wdata_i,
  input  logic                            wvalid_i,
  output logic                            wready_o,
  output logic [1:0]                      bresp_o,
  output logic                            bvalid_o,
  input  logic                            bready_i,
  input  logic [gemm_pkg::REG_AW-1:0]     araddr_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  output logic [31:0]                     rdata_o,
  output logic [1:0]                      rresp_o,
  output logic                            rvalid_o,
  input  logic                            rready_i,
  input  gemm_pkg::tile_info_t            info_i,
  input  logic                            job_done_i,
  output gemm_pkg::job_cfg_t              job_cfg_o,
  output logic                            start_o
);

  logic               init_q;
  logic               idle;
  logic               wr_en;
  logic               rd_en;
  logic               busy_q;
  logic               done_q;
  logic [31:0]        rdata_d;
  gemm_pkg::job_cfg_t cfg_q;

  // Idle once out of reset and no response is pending
  assign idle  = init_q & ~bvalid_o & ~rvalid_o;
  // AW and W are taken together, writes win over reads
  assign wr_en = idle & awvalid_i & wvalid_i;
  assign rd_en = idle & arvalid_i & ~(awvalid_i & wvalid_i);

  assign awready_o = wr_en;
  assign wready_o  = wr_en;
  assign arready_o = rd_en;
  assign bresp_o   = 2'b00;
  assign rresp_o   = 2'b00;
  assign job_cfg_o = cfg_q;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q   <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (wr_en) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_en) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // Read decode, unmapped offsets give zero
  always_comb begin
    rdata_d = '0;
    case (araddr_i)
      gemm_pkg::REG_X_ADDR:  rdata_d = cfg_q.x_addr;
      gemm_pkg::REG_W_ADDR:  rdata_d = cfg_q.w_addr;
      gemm_pkg::REG_Y_ADDR:  rdata_d = cfg_q.y_addr;
      gemm_pkg::REG_MK:      rdata_d = {cfg_q.k_size, cfg_q.m_size};
      gemm_pkg::REG_N:       rdata_d = {16'h0000, cfg_q.n_size};
      gemm_pkg::REG_STATUS:  rdata_d = {30'd0, done_q, busy_q};
      gemm_pkg::REG_TILES:   rdata_d = info_i.tot_tiles;
      gemm_pkg::REG_X_READS: rdata_d = info_i.tot_x_read[31:0];
      default:               rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_int) begin
    if (rd_en) begin
      rdata_o <= rdata_d;
    end
  end

  // Job registers, start pulse and status
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      start_o <= 1'b0;
    end else begin
      start_o <= 1'b0;
      if (wr_en) begin
        case (awaddr_i)
          gemm_pkg::REG_X_ADDR: cfg_q.x_addr <= wdata_i;
          gemm_pkg::REG_W_ADDR: cfg_q.w_addr <= wdata_i;
          gemm_pkg::REG_Y_ADDR: cfg_q.y_addr <= wdata_i;
          gemm_pkg::REG_MK: begin
            cfg_q.m_size <= wdata_i[15:0];
            cfg_q.k_size <= wdata_i[31:16];
          end
          gemm_pkg::REG_N: cfg_q.n_size <= wdata_i[15:0];
          gemm_pkg::REG_CTRL: begin
            // Restart requests during a job are dropped
            if (wdata_i[0] && !busy_q) begin
              start_o <= 1'b1;
              busy_q  <= 1'b1;
              done_q  <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      if (job_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

endmodule

//--- src/gemm_tiler.sv
// Splits a GEMM job into array tiles and builds the X, W and Y stream
// descriptors. Iteration counts come from shifts and leftover tests, the
// totals from two stages of sequential multipliers; cfg_valid_o pulses
// 33 cycles after start_i and the outputs hold until the next job.
module gemm_tiler (
  input  logic                                            clk_int,
  input  logic                                            rst_ni,
  input  gemm_pkg::job_cfg_t                              job_cfg_i,
  input  logic                                            start_i,
  output gemm_pkg::stream_desc_t [gemm_pkg::N_STREAMS-1:0] descs_o,
  output gemm_pkg::tile_info_t                            info_o,
  output logic                                            cfg_valid_o
);

  gemm_pkg::job_cfg_t cfg_q;
  logic [15:0]        x_rows_iter;
  logic [15:0]        w_cols_iter;
  logic [15:0]        x_cols_iter;
  logic [47:0]        tiles_prod;
  logic [47:0]        x_reads_prod;
  logic [47:0]        w_len_prod;
  logic [31:0]        tot_tiles;
  logic [31:0]        elem_stride;
  logic               tiles_valid;
  logic               tiles_valid_q;
  logic               tiles_done;
  logic               x_reads_valid;
  logic               w_len_valid;
  logic               counts_valid;
  logic               counts_valid_q;
  logic               counts_done;

  // Job snapshot, the host may rewrite the registers during a job
  always_ff @(posedge clk_int) begin
    if (start_i) begin
      cfg_q <= job_cfg_i;
    end
  end

  // Rounded-up iteration counts
  assign x_rows_iter = (job_cfg_i.m_size >> gemm_pkg::ARRAY_SHIFT)
                     + 16'(job_cfg_i.m_size[gemm_pkg::ARRAY_SHIFT-1:0] != '0);
  assign w_cols_iter = (job_cfg_i.k_size >> gemm_pkg::TILE_SHIFT)
                     + 16'(job_cfg_i.k_size[gemm_pkg::TILE_SHIFT-1:0] != '0);
  assign x_cols_iter = (cfg_q.n_size >> gemm_pkg::TILE_SHIFT)
                     + 16'(cfg_q.n_size[gemm_pkg::TILE_SHIFT-1:0] != '0);

  // tiles = x_rows_iter * w_cols_iter
  gemm_seq_mult i_tiles_mult (
    .clk_int ( clk_int             ),
    .rst_ni  ( rst_ni              ),
    .start_i ( start_i             ),
    .a_i     ( x_rows_iter         ),
    .b_i     ( {16'h0000, w_cols_iter} ),
    .valid_o ( tiles_valid         ),
    .prod_o  ( tiles_prod          )
  );

  assign tot_tiles  = tiles_prod[31:0];
  assign tiles_done = tiles_valid & ~tiles_valid_q;

  // Second stage starts on the rising edge of the tile count
  gemm_seq_mult i_x_reads_mult (
    .clk_int ( clk_int       ),
    .rst_ni  ( rst_ni        ),
    .start_i ( tiles_done    ),
    .a_i     ( x_cols_iter   ),
    .b_i     ( tot_tiles     ),
    .valid_o ( x_reads_valid ),
    .prod_o  ( x_reads_prod  )
  );

  gemm_seq_mult i_w_len_mult (
    .clk_int ( clk_int      ),
    .rst_ni  ( rst_ni       ),
    .start_i ( tiles_done   ),
    .a_i     ( cfg_q.n_size ),
    .b_i     ( tot_tiles    ),
    .valid_o ( w_len_valid  ),
    .prod_o  ( w_len_prod   )
  );

  assign counts_valid = x_reads_valid & w_len_valid;
  assign counts_done  = counts_valid & ~counts_valid_q;
  assign elem_stride  = 32'(cfg_q.k_size) * gemm_pkg::ELEM_BYTES;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      tiles_valid_q  <= 1'b0;
      counts_valid_q <= 1'b0;
      cfg_valid_o    <= 1'b0;
    end else begin
      tiles_valid_q  <= tiles_valid;
      counts_valid_q <= counts_valid;
      cfg_valid_o    <= counts_done;
    end
  end

  always_ff @(posedge clk_int) begin
    if (counts_done) begin
      descs_o[gemm_pkg::STREAM_X] <= '{base:   cfg_q.x_addr,
                                       stride: gemm_pkg::TILE_BYTES,
                                       len:    x_reads_prod[31:0]};
      descs_o[gemm_pkg::STREAM_W] <= '{base:   cfg_q.w_addr,
                                       stride: elem_stride,
                                       len:    w_len_prod[31:0]};
      // One output row per array row and tile
      descs_o[gemm_pkg::STREAM_Y] <= '{base:   cfg_q.y_addr,
                                       stride: elem_stride,
                                       len:    tot_tiles * gemm_pkg::ARRAY_WIDTH};
      info_o <= '{tot_tiles: tot_tiles, tot_x_read: x_reads_prod};
    end
  end

endmodule

//--- src/gemm_stream_agu.sv
// Address generator for one stream. A descriptor is loaded on load_i,
// then item i carries base + i * stride, one item per accepted handshake.
// idle_o is high once the last item has been taken.
module gemm_stream_agu (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  input  gemm_pkg::stream_desc_t desc_i,
  input  logic                   load_i,
  output gemm_pkg::addr_req_t    item_o,
  output logic                   item_valid_o,
  input  logic                   item_ready_i,
  output logic                   idle_o
);

  logic [31:0] addr_q;
  logic [31:0] stride_q;
  logic [31:0] rem_q;
  logic        step;

  assign step = item_valid_o & item_ready_i;

  // Remaining item count
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q <= '0;
    end else if (load_i) begin
      rem_q <= desc_i.len;
    end else if (step) begin
      rem_q <= rem_q - 1'b1;
    end
  end

  // Running address, wraps modulo 2^32
  always_ff @(posedge clk_int) begin
    if (load_i) begin
      addr_q   <= desc_i.base;
      stride_q <= desc_i.stride;
    end else if (step) begin
      addr_q <= addr_q + stride_q;
    end
  end

  assign item_valid_o = (rem_q != '0);
  assign idle_o       = ~item_valid_o;
  // The stream id is stamped by the generate loop of the top level
  assign item_o.addr  = addr_q;
  assign item_o.sid   = '0;

endmodule

//--- src/gemm_addr_merger.sv
// Round-robin merger of the stream generators into one request port.
// A registered slot moves only when accepted, so req_o holds under
// back-pressure. job_done_o pulses once an armed job has fully drained.
module gemm_addr_merger (
  input  logic                                         clk_int,
  input  logic                                         rst_ni,
  input  logic                                         armed_i,
  input  gemm_pkg::addr_req_t [gemm_pkg::N_STREAMS-1:0] items_i,
  input  logic [gemm_pkg::N_STREAMS-1:0]               items_valid_i,
  output logic [gemm_pkg::N_STREAMS-1:0]               items_ready_o,
  input  logic [gemm_pkg::N_STREAMS-1:0]               idle_i,
  output gemm_pkg::addr_req_t                          req_o,
  output logic                                         req_valid_o,
  input  logic                                         req_ready_i,
  output logic                                         job_done_o
);

  logic [gemm_pkg::SID_BITS-1:0] ptr_q;
  logic [gemm_pkg::SID_BITS-1:0] grant;
  logic                          found;
  logic                          slot_free;
  logic                          armed_q;

  assign slot_free = ~req_valid_o | req_ready_i;

  // First valid generator at or after the pointer
  always_comb begin
    int unsigned idx;
    grant = ptr_q;
    found = 1'b0;
    for (int unsigned off = 0; off < gemm_pkg::N_STREAMS; off++) begin
      idx = ptr_q + off;
      if (idx >= gemm_pkg::N_STREAMS) begin
        idx = idx - gemm_pkg::N_STREAMS;
      end
      if (!found && items_valid_i[idx]) begin
        grant = idx[gemm_pkg::SID_BITS-1:0];
        found = 1'b1;
      end
    end
    items_ready_o        = '0;
    items_ready_o[grant] = found & slot_free;
  end

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_o <= 1'b0;
      ptr_q       <= '0;
    end else if (slot_free) begin
      req_valid_o <= found;
      if (found) begin
        ptr_q <= (grant == gemm_pkg::N_STREAMS - 1) ? '0 : grant + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_int) begin
    if (slot_free && found) begin
      req_o <= items_i[grant];
    end
  end

  // Completion once every generator is idle and the slot is empty
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q    <= 1'b0;
      job_done_o <= 1'b0;
    end else begin
      job_done_o <= 1'b0;
      if (armed_i) begin
        armed_q <= 1'b1;
      end else if (armed_q && (&idle_i) && !req_valid_o) begin
        armed_q    <= 1'b0;
        job_done_o <= 1'b1;
      end
    end
  end

endmodule

//--- src/gemm_ctrl_top.sv
// Top level of the GEMM control front end: register file, tiler, one
// address generator per stream and the request merger.
// irq_o pulses for one cycle when a job has issued all its addresses.
module gemm_ctrl_top (
  input  logic                        clk_int,
  input  logic                        rst_ni,
  input  logic [gemm_pkg::REG_AW-1:0] awaddr_i,
  input  logic                        awvalid_i,
  output logic                        awready_o,
  input  logic [31:0]                 wdata_i,
  input  logic                        wvalid_i,
  output logic                        wready_o,
  output logic [1:0]                  bresp_o,
  output logic                        bvalid_o,
  input  logic                        bready_i,
  input  logic [gemm_pkg::REG_AW-1:0] araddr_i,
  input  logic                        arvalid_i,
  output logic                        arready_o,
  output logic [31:0]                 rdata_o,
  output logic [1:0]                  rresp_o,
  output logic                        rvalid_o,
  input  logic                        rready_i,
  output gemm_pkg::addr_req_t         req_o,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  output logic                        irq_o
);

  gemm_pkg::job_cfg_t                               job_cfg;
  logic                                             start;
  gemm_pkg::stream_desc_t [gemm_pkg::N_STREAMS-1:0] descs;
  gemm_pkg::tile_info_t                             info;
  logic                                             cfg_valid;
  gemm_pkg::addr_req_t    [gemm_pkg::N_STREAMS-1:0] agu_items;
  gemm_pkg::addr_req_t    [gemm_pkg::N_STREAMS-1:0] items;
  logic                   [gemm_pkg::N_STREAMS-1:0] items_valid;
  logic                   [gemm_pkg::N_STREAMS-1:0] items_ready;
  logic                   [gemm_pkg::N_STREAMS-1:0] idle;

  gemm_regfile i_regfile (
    .clk_int, .rst_ni,
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .info_i     ( info    ),
    .job_done_i ( irq_o   ),
    .job_cfg_o  ( job_cfg ),
    .start_o    ( start   )
  );

  gemm_tiler i_tiler (
    .clk_int, .rst_ni,
    .job_cfg_i   ( job_cfg   ),
    .start_i     ( start     ),
    .descs_o     ( descs     ),
    .info_o      ( info      ),
    .cfg_valid_o ( cfg_valid )
  );

  for (genvar i = 0; i < gemm_pkg::N_STREAMS; i++) begin : g_agu
    localparam int unsigned STREAM_ID = i;

    gemm_stream_agu i_agu (
      .clk_int, .rst_ni,
      .desc_i       ( descs[i]       ),
      .load_i       ( cfg_valid      ),
      .item_o       ( agu_items[i]   ),
      .item_valid_o ( items_valid[i] ),
      .item_ready_i ( items_ready[i] ),
      .idle_o       ( idle[i]        )
    );

    // Tag each generator's items with its stream number
    assign items[i] = '{addr: agu_items[i].addr,
                        sid:  STREAM_ID[gemm_pkg::SID_BITS-1:0]};
  end

  gemm_addr_merger i_merger (
    .clk_int, .rst_ni,
    .armed_i       ( cfg_valid   ),
    .items_i       ( items       ),
    .items_valid_i ( items_valid ),
    .items_ready_o ( items_ready ),
    .idle_i        ( idle        ),
    .req_o, .req_valid_o, .req_ready_i,
    .job_done_o    ( irq_o       )
  );

endmodule

//--- verif/tb_clkgen.sv
// Clock and reset source for the GEMM front-end testbench.
// clk_int runs with an 8 ns period, rst_ni is released after 8 rising edges.
module tb_clkgen (
  output logic clk_int,
  output logic rst_ni
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RESET_CYCLES = 8;

  initial begin
    clk_int = 1'b0;
    forever #4 clk_int = ~clk_int;
  end

  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_int);
    rst_ni <= 1'b1;
  end

endmodule

//--- verif/gemm_ctrl_chk.sv
// Protocol checks on the GEMM front-end top level, attached with bind.
// Covers request stability under back-pressure, the irq pulse width and
// the AXI4-Lite write response hold rule.
module gemm_ctrl_chk (
  input logic                clk_int,
  input logic                rst_ni,
  input gemm_pkg::addr_req_t req_o,
  input logic                req_valid_o,
  input logic                req_ready_i,
  input logic                irq_o,
  input logic                bvalid_o,
  input logic                bready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Set by any failing property, watched by the testbench
  logic failed = 1'b0;

  // A stalled request keeps its valid and payload
  req_hold: assert property (@(posedge clk_int) disable iff (!rst_ni)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o))
    else begin
      failed = 1'b1;
      $error("request changed or dropped while stalled");
    end

  irq_pulse: assert property (@(posedge clk_int) disable iff (!rst_ni)
    irq_o |=> !irq_o)
    else begin
      failed = 1'b1;
      $error("irq_o high for more than one cycle");
    end

  b_hold: assert property (@(posedge clk_int) disable iff (!rst_ni)
    bvalid_o && !bready_i |=> bvalid_o)
    else begin
      failed = 1'b1;
      $error("bvalid_o dropped before bready_i");
    end

endmodule

//--- verif/tb_gemm_ctrl.sv
// Testbench of the GEMM control front end. Programs random jobs over
// AXI4-Lite, models the tiling rule and the three address streams, and
// compares every request and count readback. req_ready_i toggles randomly.
module tb_gemm_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned N_JOBS         = 20;
  localparam int unsigned QUIET_CYCLES   = 40;
  localparam int unsigned RESTART_MARGIN = 16;
  localparam logic [31:0] SEED           = 32'h09c0_76a8;

  typedef struct packed {
    logic [31:0] tiles;
    logic [47:0] x_reads;
    logic [31:0] w_len;
    logic [31:0] y_len;
  } tiling_t;

  logic                        clk_int;
  logic                        rst_ni;
  logic [gemm_pkg::REG_AW-1:0] awaddr_i;
  logic                        awvalid_i;
  logic                        awready_o;
  logic [31:0]                 wdata_i;
  logic                        wvalid_i;
  logic                        wready_o;
  logic [1:0]                  bresp_o;
  logic                        bvalid_o;
  logic                        bready_i;
  logic [gemm_pkg::REG_AW-1:0] araddr_i;
  logic                        arvalid_i;
  logic                        arready_o;
  logic [31:0]                 rdata_o;
  logic [1:0]                  rresp_o;
  logic                        rvalid_o;
  logic                        rready_i;
  gemm_pkg::addr_req_t         req_o;
  logic                        req_valid_o;
  logic                        req_ready_i;
  logic                        irq_o;

  logic [31:0]        exp_q [gemm_pkg::N_STREAMS][$];
  int unsigned        irq_count = 0;
  longint unsigned    cycle_cnt = 0;
  longint unsigned    cycle_limit = 64'hFFFF_FFFF;
  gemm_pkg::job_cfg_t jobs [N_JOBS];

  tb_clkgen i_clkgen (.clk_int, .rst_ni);

  gemm_ctrl_top DUT (.*);

  bind gemm_ctrl_top gemm_ctrl_chk i_chk (.clk_int, .rst_ni, .req_o, .req_valid_o,
                                          .req_ready_i, .irq_o, .bvalid_o, .bready_i);

  task automatic end_in_failure();
    $display("Test failures found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic mismatch_stop(input string what);
    $display("mismatch at %0t ns: %s", $time, what);
    end_in_failure();
  endtask

  task automatic problem_stop(input string what);
    $display("%s", what);
    end_in_failure();
  endtask

  function automatic int unsigned ceil_div(input int unsigned a, input int unsigned d);
    return (a + d - 1) / d;
  endfunction

  // Tiling rule of the front end
  function automatic tiling_t compute_tiling(input gemm_pkg::job_cfg_t cfg);
    tiling_t     t;
    int unsigned rows;
    int unsigned x_cols;
    int unsigned w_cols;
    rows    = ceil_div(int'(cfg.m_size), gemm_pkg::ARRAY_WIDTH);
    x_cols  = ceil_div(int'(cfg.n_size), gemm_pkg::TILE_COLS);
    w_cols  = ceil_div(int'(cfg.k_size), gemm_pkg::TILE_COLS);
    t.tiles = rows * w_cols;
    t.x_reads = 48'(longint'(t.tiles) * longint'(x_cols));
    t.w_len = t.tiles * 32'(cfg.n_size);
    t.y_len = t.tiles * gemm_pkg::ARRAY_WIDTH;
    return t;
  endfunction

  // Items still expected over all streams
  function automatic int unsigned items_left();
    int unsigned n;
    n = 0;
    for (int s = 0; s < gemm_pkg::N_STREAMS; s++) begin
      n += exp_q[s].size();
    end
    return n;
  endfunction

  // Expected address sequence per stream: base + i * stride
  task automatic load_expected(input gemm_pkg::job_cfg_t cfg, input tiling_t t);
    logic [31:0] base [gemm_pkg::N_STREAMS];
    logic [31:0] stride [gemm_pkg::N_STREAMS];
    logic [31:0] len [gemm_pkg::N_STREAMS];
    logic [31:0] addr;
    base   = '{cfg.x_addr, cfg.w_addr, cfg.y_addr};
    stride = '{gemm_pkg::TILE_BYTES, gemm_pkg::ELEM_BYTES * 32'(cfg.k_size),
               gemm_pkg::ELEM_BYTES * 32'(cfg.k_size)};
    len    = '{t.x_reads[31:0], t.w_len, t.y_len};
    for (int s = 0; s < gemm_pkg::N_STREAMS; s++) begin
      addr = base[s];
      for (longint unsigned i = 0; i < len[s]; i++) begin
        exp_q[s].push_back(addr);
        addr = addr + stride[s];
      end
    end
  endtask

  task automatic write_reg(input logic [gemm_pkg::REG_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk_int);
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    wdata_i   <= data;
    wvalid_i  <= 1'b1;
    bready_i  <= 1'b1;
    @(negedge clk_int);
    while (!awready_o) @(negedge clk_int);
    assert (wready_o)
      else problem_stop("write data was not accepted together with the write address");
    @(posedge clk_int);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    @(negedge clk_int);
    while (!bvalid_o) @(negedge clk_int);
    assert (bresp_o == 2'b00)
      else mismatch_stop($sformatf("bresp 0x%0h at offset 0x%02h", bresp_o, addr));
    @(posedge clk_int);
    bready_i <= 1'b0;
  endtask

  task automatic read_reg(input logic [gemm_pkg::REG_AW-1:0] addr, output logic [31:0] data);
    @(posedge clk_int);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    rready_i  <= 1'b1;
    @(negedge clk_int);
    while (!arready_o) @(negedge clk_int);
    @(posedge clk_int);
    arvalid_i <= 1'b0;
    @(negedge clk_int);
    while (!rvalid_o) @(negedge clk_int);
    data = rdata_o;
    assert (rresp_o == 2'b00)
      else mismatch_stop($sformatf("rresp 0x%0h at offset 0x%02h", rresp_o, addr));
    @(posedge clk_int);
    rready_i <= 1'b0;
  endtask

  task automatic expect_reg(input logic [gemm_pkg::REG_AW-1:0] addr, input logic [31:0] want);
    logic [31:0] got;
    read_reg(addr, got);
    assert (got == want)
      else mismatch_stop($sformatf("offset 0x%02h read 0x%08h, expected 0x%08h",
                                   addr, got, want));
  endtask

  task automatic check_readback();
    logic [gemm_pkg::REG_AW-1:0] offs [5];
    logic [gemm_pkg::REG_AW-1:0] holes [4];
    logic [31:0]                 vals [5];
    offs  = '{gemm_pkg::REG_X_ADDR, gemm_pkg::REG_W_ADDR, gemm_pkg::REG_Y_ADDR,
              gemm_pkg::REG_MK, gemm_pkg::REG_N};
    holes = '{8'h24, 8'h30, 8'h7C, 8'hFC};
    expect_reg(gemm_pkg::REG_STATUS, 32'h0);
    for (int i = 0; i < 5; i++) begin
      vals[i] = $urandom();
      write_reg(offs[i], vals[i]);
    end
    // N keeps only the 16-bit size
    vals[4] = vals[4] & 32'h0000_FFFF;
    for (int i = 0; i < 5; i++) begin
      expect_reg(offs[i], vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      expect_reg(holes[i], 32'h0);
    end
  endtask

  task automatic check_item(input gemm_pkg::addr_req_t item);
    logic [31:0] want;
    assert (item.sid < gemm_pkg::N_STREAMS)
      else problem_stop($sformatf("request with invalid stream id %0d", item.sid));
    assert (exp_q[item.sid].size() != 0)
      else problem_stop($sformatf("extra request on stream %0d at %0t ns", item.sid, $time));
    want = exp_q[item.sid].pop_front();
    assert (item.addr == want)
      else mismatch_stop($sformatf("stream %0d address 0x%08h, expected 0x%08h",
                                   item.sid, item.addr, want));
  endtask

  task automatic run_job(input gemm_pkg::job_cfg_t cfg);
    tiling_t     t;
    int unsigned irq_before;
    int unsigned total;
    t = compute_tiling(cfg);
    load_expected(cfg, t);
    total = items_left();
    write_reg(gemm_pkg::REG_X_ADDR, cfg.x_addr);
    write_reg(gemm_pkg::REG_W_ADDR, cfg.w_addr);
    write_reg(gemm_pkg::REG_Y_ADDR, cfg.y_addr);
    write_reg(gemm_pkg::REG_MK, {cfg.k_size, cfg.m_size});
    write_reg(gemm_pkg::REG_N, {16'h0000, cfg.n_size});
    irq_before = irq_count;
    write_reg(gemm_pkg::REG_CTRL, 32'h1);
    expect_reg(gemm_pkg::REG_STATUS, 32'h1);
    // Second start while busy must be dropped, on long jobs once the streams run
    if (total > RESTART_MARGIN) begin
      while (items_left() == total) @(negedge clk_int);
    end
    write_reg(gemm_pkg::REG_CTRL, 32'h1);
    while (irq_count == irq_before) @(negedge clk_int);
    expect_reg(gemm_pkg::REG_STATUS, 32'h2);
    expect_reg(gemm_pkg::REG_TILES, t.tiles);
    expect_reg(gemm_pkg::REG_X_READS, t.x_reads[31:0]);
    for (int s = 0; s < gemm_pkg::N_STREAMS; s++) begin
      assert (exp_q[s].size() == 0)
        else mismatch_stop($sformatf("stream %0d ended %0d items short", s, exp_q[s].size()));
    end
    repeat (QUIET_CYCLES) @(negedge clk_int);
    assert (irq_count == irq_before + 1)
      else problem_stop("a start written while busy caused an extra interrupt");
  endtask

  // Random back-pressure, about 70 % ready
  always @(posedge clk_int) begin
    req_ready_i <= ($urandom_range(99, 0) < 70);
  end

  // Request and interrupt monitor, sampled mid-cycle
  always @(negedge clk_int) begin
    if (rst_ni) begin
      if (req_valid_o && req_ready_i) begin
        check_item(req_o);
      end
      if (irq_o) begin
        irq_count++;
      end
    end
  end

  // Bound protocol checker
  always @(negedge clk_int) begin
    if (DUT.i_chk.failed) begin
      problem_stop("a protocol assertion on the DUT failed");
    end
  end

  always @(posedge clk_int) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      problem_stop($sformatf("timeout after %0d cycles without finishing", cycle_cnt));
    end
  end

  initial begin
    longint unsigned budget;
    tiling_t         t;
    awaddr_i    = '0;
    awvalid_i   = 1'b0;
    wdata_i     = '0;
    wvalid_i    = 1'b0;
    bready_i    = 1'b0;
    araddr_i    = '0;
    arvalid_i   = 1'b0;
    rready_i    = 1'b0;
    req_ready_i = 1'b0;
    void'($urandom(SEED));
    for (int j = 0; j < N_JOBS; j++) begin
      jobs[j] = '{x_addr: $urandom(), w_addr: $urandom(), y_addr: $urandom(),
                  m_size: 16'($urandom_range(40, 0)), k_size: 16'($urandom_range(40, 0)),
                  n_size: 16'($urandom_range(40, 0))};
    end
    // Empty job, exact multiples, leftovers and the largest job near the top
    jobs[0].m_size = 16'd0;
    {jobs[1].m_size, jobs[1].n_size, jobs[1].k_size} = {16'd8, 16'd16, 16'd16};
    {jobs[2].m_size, jobs[2].n_size, jobs[2].k_size} = {16'd5, 16'd9, 16'd17};
    {jobs[3].m_size, jobs[3].n_size, jobs[3].k_size} = {16'd40, 16'd40, 16'd40};
    jobs[3].x_addr = 32'hFFFF_FFF0;
    budget = 0;
    for (int j = 0; j < N_JOBS; j++) begin
      t = compute_tiling(jobs[j]);
      budget += (longint'(t.x_reads) + t.w_len + t.y_len) * 4 + 100;
    end
    cycle_limit = budget;
    wait (rst_ni);
    check_readback();
    for (int j = 0; j < N_JOBS; j++) begin
      run_job(jobs[j]);
    end
    if (DUT.i_chk.failed) begin
      problem_stop("a protocol assertion on the DUT failed");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

//--- files.f
src/gemm_pkg.sv
src/gemm_seq_mult.sv
src/gemm_regfile.sv
src/gemm_tiler.sv
src/gemm_stream_agu.sv
src/gemm_addr_merger.sv
src/gemm_ctrl_top.sv
verif/tb_clkgen.sv
verif/gemm_ctrl_chk.sv
verif/tb_gemm_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the GEMM front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_gemm_ctrl -f files.f -o sim_gemm_ctrl

out=$(./obj_dir/sim_gemm_ctrl 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
else
  echo "simulation failed"
  exit 1
fi
